/* Bender.yml */
package:
  name: lookup_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/pio_pkg.sv
      - hw/lookup_pkg.sv
      - hw/ram_1r1w.sv
      - hw/pio_table_mem.sv
      - hw/lookup_issue.sv
      - hw/action_apply.sv
      - hw/lookup_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_lookup_top.sv

/* flist.f */
+incdir+hw
hw/pio_pkg.sv
hw/lookup_pkg.sv
hw/ram_1r1w.sv
hw/pio_table_mem.sv
hw/lookup_issue.sv
hw/action_apply.sv
hw/lookup_top.sv
verification/tb_lookup_top.sv

/* hw/action_apply.sv */
// action stage.
// applies the table action, buffers results, sends against output credits.
`timescale 1ns/1ps
`default_nettype none

`include "lookup_defines.svh"

module action_apply (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire lookup_pkg::lk_req_t    stage_req,
	input  wire logic                   tbl_ack,
	input  wire lookup_pkg::tbl_entry_t tbl_entry,
	input  wire logic                   out_credit,
	output lookup_pkg::lk_rsp_t         rsp,
	output logic                        in_credit
);

	localparam int PTR_W = $clog2(`LK_CREDITS);
	localparam int CNT_W = $clog2(`LK_CREDITS + 1);

	// action decode.
	logic                         hit;
	logic                         drop;
	logic                         push;
	logic [`LK_PAYLOAD_NBITS-1:0] result;

	// output buffer.
	logic [`TBL_DEPTH_NBITS-1:0]  fifo_idx [`LK_CREDITS];
	logic [`LK_PAYLOAD_NBITS-1:0] fifo_pay [`LK_CREDITS];
	logic [PTR_W-1:0]             wr_ptr_q;
	logic [PTR_W-1:0]             rd_ptr_q;
	logic [CNT_W-1:0]             count_q;

	// downstream credits held.
	logic [CNT_W-1:0] out_cnt_q;
	logic             send;

	// credits owed upstream beyond this cycle's pulse.
	logic [CNT_W-1:0] credit_owed_q;
	logic [CNT_W-1:0] credit_total;
	logic             credit_q;

	// registered result.
	logic                         rsp_vld_q;
	logic [`TBL_DEPTH_NBITS-1:0]  rsp_idx_q;
	logic [`LK_PAYLOAD_NBITS-1:0] rsp_pay_q;

	assign hit = stage_req.valid & tbl_ack;
	assign drop = hit & (tbl_entry.op == lookup_pkg::act_drop);
	assign push = hit & ~drop;

	// add wraps at 16 bits.
	always_comb begin
		case (tbl_entry.op)
			lookup_pkg::act_add: result = stage_req.payload + tbl_entry.operand;
			lookup_pkg::act_xor: result = stage_req.payload ^ tbl_entry.operand;
			default:             result = stage_req.payload;
		endcase
	end

	// head goes out when buffered and credited.
	assign send = (count_q != '0) & (out_cnt_q != '0);

	// send and drop in one cycle owe two credits.
	assign credit_total = credit_owed_q + {{(CNT_W-1){1'b0}}, send}
		+ {{(CNT_W-1){1'b0}}, drop};

	// buffer and result payload, no reset.
	always_ff @(posedge clk) begin
		if (push) begin
			fifo_idx[wr_ptr_q] <= stage_req.index;
			fifo_pay[wr_ptr_q] <= result;
		end
		if (send) begin
			rsp_idx_q <= fifo_idx[rd_ptr_q];
			rsp_pay_q <= fifo_pay[rd_ptr_q];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			out_cnt_q <= CNT_W'(`LK_CREDITS);
			credit_owed_q <= '0;
			credit_q <= 1'b0;
			rsp_vld_q <= 1'b0;
		end else begin
			// pointers wrap on the power-of-two depth.
			if (push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (send) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			count_q <= count_q + {{(CNT_W-1){1'b0}}, push} - {{(CNT_W-1){1'b0}}, send};
			out_cnt_q <= out_cnt_q + {{(CNT_W-1){1'b0}}, out_credit}
				- {{(CNT_W-1){1'b0}}, send};
			// one pulse per cycle, the rest carried over.
			credit_q <= (credit_total != '0);
			credit_owed_q <= (credit_total != '0) ? credit_total - 1'b1 : '0;
			rsp_vld_q <= send;
		end
	end

	assign in_credit = credit_q;
	assign rsp = '{valid: rsp_vld_q, index: rsp_idx_q, payload: rsp_pay_q};

endmodule

`default_nettype wire

/* hw/lookup_defines.svh */
// flow-action lookup engine.
// shared widths, table geometry and stream credit count.
`ifndef LOOKUP_DEFINES_SVH
`define LOOKUP_DEFINES_SVH

// pio register bus data and address width.
`define PIO_NBITS 32

// table index width, 64 entries.
`define TBL_DEPTH_NBITS 6

// table entry width, action plus 16-bit operand.
`define TBL_WIDTH 18

// lookup payload width.
`define LK_PAYLOAD_NBITS 16

// credits held at each stream port.
// also the depth of the output buffer.
`define LK_CREDITS 4

`endif

/* hw/lookup_issue.sv */
// lookup issue stage.
// starts the table read and carries the request beside it.
`timescale 1ns/1ps
`default_nettype none

`include "lookup_defines.svh"

module lookup_issue (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire lookup_pkg::lk_req_t         req,
	output logic                             tbl_rd,
	output logic [`TBL_DEPTH_NBITS-1:0]      tbl_index,
	output lookup_pkg::lk_req_t              stage_req
);

	// matches the table read latency.
	localparam int LAT = 3;

	// delay line, valids reset, data does not.
	logic [LAT-1:0]               vld_q;
	logic [`TBL_DEPTH_NBITS-1:0]  idx_q [LAT];
	logic [`LK_PAYLOAD_NBITS-1:0] pay_q [LAT];

	// upstream only sends while holding a credit.
	// so every valid request becomes a read.
	assign tbl_rd = req.valid;
	assign tbl_index = req.index;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[LAT-2:0], req.valid};
		end
	end

	// index and payload shift along with the valid.
	always_ff @(posedge clk) begin
		idx_q[0] <= req.index;
		pay_q[0] <= req.payload;
		for (int i = 1; i < LAT; i++) begin
			idx_q[i] <= idx_q[i-1];
			pay_q[i] <= pay_q[i-1];
		end
	end

	// lines up with tbl_ack.
	assign stage_req = '{
		valid:   vld_q[LAT-1],
		index:   idx_q[LAT-1],
		payload: pay_q[LAT-1]
	};

endmodule

`default_nettype wire

/* hw/lookup_pkg.sv */
// lookup stream and action table types.
// shared by the issue, table and action stages.
`default_nettype none

`include "lookup_defines.svh"

package lookup_pkg;

	// action stored with each table entry.
	typedef enum logic [1:0] {
		act_pass = 2'd0,
		act_add  = 2'd1,
		act_xor  = 2'd2,
		act_drop = 2'd3
	} action_e;

	// table entry, action in the top two bits.
	typedef struct packed {
		action_e                      op;
		logic [`LK_PAYLOAD_NBITS-1:0] operand;
	} tbl_entry_t;

	// lookup request from upstream.
	typedef struct packed {
		logic                         valid;
		logic [`TBL_DEPTH_NBITS-1:0]  index;
		logic [`LK_PAYLOAD_NBITS-1:0] payload;
	} lk_req_t;

	// lookup result to downstream.
	// payload here is the transformed value.
	typedef struct packed {
		logic                         valid;
		logic [`TBL_DEPTH_NBITS-1:0]  index;
		logic [`LK_PAYLOAD_NBITS-1:0] payload;
	} lk_rsp_t;

endpackage

`default_nettype wire

/* hw/lookup_top.sv */
// flow-action lookup engine top.
// issue, table memory and action stages with stream and pio ports.
`timescale 1ns/1ps
`default_nettype none

`include "lookup_defines.svh"

module lookup_top (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                pio_clk_en,
	input  wire pio_pkg::pio_req_t   pio,
	input  wire lookup_pkg::lk_req_t req,
	input  wire logic                out_credit,
	output pio_pkg::pio_rsp_t        pio_rsp,
	output logic                     wr_active,
	output lookup_pkg::lk_rsp_t      rsp,
	output logic                     in_credit
);

	// issue to table.
	logic                        tbl_rd;
	logic [`TBL_DEPTH_NBITS-1:0] tbl_index;

	// table and delayed request to action.
	lookup_pkg::lk_req_t    stage_req;
	logic                   tbl_ack;
	lookup_pkg::tbl_entry_t tbl_entry;

	lookup_issue u_issue (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.tbl_rd   (tbl_rd),
		.tbl_index(tbl_index),
		.stage_req(stage_req)
	);

	// wr_active is a write strobe for software tracing.
	pio_table_mem u_table (
		.clk       (clk),
		.rst_n     (rst_n),
		.pio_clk_en(pio_clk_en),
		.pio       (pio),
		.tbl_rd    (tbl_rd),
		.tbl_index (tbl_index),
		.pio_rsp   (pio_rsp),
		.tbl_ack   (tbl_ack),
		.tbl_entry (tbl_entry),
		.wr_active (wr_active)
	);

	action_apply u_action (
		.clk       (clk),
		.rst_n     (rst_n),
		.stage_req (stage_req),
		.tbl_ack   (tbl_ack),
		.tbl_entry (tbl_entry),
		.out_credit(out_credit),
		.rsp       (rsp),
		.in_credit (in_credit)
	);

endmodule

`default_nettype wire

/* hw/pio_pkg.sv */
// pio register bus types.
// request and response as seen by a memory-mapped block.
`default_nettype none

`include "lookup_defines.svh"

package pio_pkg;

	// request from the software side.
	// word address is addr with the two low bits dropped.
	typedef struct packed {
		logic [`PIO_NBITS-1:0] addr;
		logic [`PIO_NBITS-1:0] wdata;
		logic                  rd;
		logic                  wr;
		// block select, qualifies rd and wr.
		logic                  sel;
	} pio_req_t;

	// response back to the software side.
	typedef struct packed {
		// stretched to the next slow-clock enable.
		logic                  ack;
		// holds its value after the ack.
		logic [`PIO_NBITS-1:0] rdata;
	} pio_rsp_t;

endpackage

`default_nettype wire

/* hw/pio_table_mem.sv */
// pio accessible action table.
// application reads win the read port, pio acks wait for the slow clock.
`timescale 1ns/1ps
`default_nettype none

`include "lookup_defines.svh"

module pio_table_mem (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic                        pio_clk_en,
	input  wire pio_pkg::pio_req_t           pio,
	input  wire logic                        tbl_rd,
	input  wire logic [`TBL_DEPTH_NBITS-1:0] tbl_index,
	output pio_pkg::pio_rsp_t                pio_rsp,
	output logic                             tbl_ack,
	output lookup_pkg::tbl_entry_t           tbl_entry,
	output logic                             wr_active
);

	// word address from the byte address.
	logic [`TBL_DEPTH_NBITS-1:0] pio_addr_dw;

	// pio strobes, qualified by select.
	logic ram_wr;
	logic pio_rd;

	// application read, address register stage.
	logic                        app_rd_d1;
	logic                        app_rd_d2;
	logic [`TBL_DEPTH_NBITS-1:0] app_raddr_d1;

	// pio read that lost the port.
	logic                        rd_save_q;
	logic [`TBL_DEPTH_NBITS-1:0] rd_addr_q;

	// pio read gets the port this cycle.
	logic pio_rd_grant;
	logic pio_rd_grant_d1;

	// ack pending until the next slow-clock enable.
	logic ack_pend_q;
	logic ack_q;
	logic [`PIO_NBITS-1:0] rdata_q;

	logic [`TBL_DEPTH_NBITS-1:0] ram_raddr;
	logic [`TBL_DEPTH_NBITS-1:0] pio_raddr;
	logic [`TBL_WIDTH-1:0]       ram_rdata;

	assign pio_addr_dw = pio.addr[`TBL_DEPTH_NBITS+1:2];
	assign ram_wr = pio.sel & pio.wr;
	assign pio_rd = pio.sel & pio.rd;

	// a fresh read uses the bus address, a saved one its stored copy.
	assign pio_raddr = pio_rd ? pio_addr_dw : rd_addr_q;

	// served only when no application read holds the port.
	assign pio_rd_grant = ~app_rd_d1 & (pio_rd | rd_save_q);

	// application address wins.
	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : pio_raddr;

	// payload registers.
	always_ff @(posedge clk) begin
		app_raddr_d1 <= tbl_index;
		tbl_entry <= lookup_pkg::tbl_entry_t'(ram_rdata);
		if (pio_rd) begin
			rd_addr_q <= pio_addr_dw;
		end
		// zero-extend to the bus width.
		if (pio_rd_grant_d1) begin
			rdata_q <= {{(`PIO_NBITS-`TBL_WIDTH){1'b0}}, ram_rdata};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			tbl_ack <= 1'b0;
			rd_save_q <= 1'b0;
			pio_rd_grant_d1 <= 1'b0;
			ack_pend_q <= 1'b0;
			ack_q <= 1'b0;
			wr_active <= 1'b0;
		end else begin
			// three cycles from tbl_rd to tbl_ack.
			app_rd_d1 <= tbl_rd;
			app_rd_d2 <= app_rd_d1;
			tbl_ack <= app_rd_d2;
			// save on collision, clear once served.
			if (app_rd_d1 & pio_rd) begin
				rd_save_q <= 1'b1;
			end else if (pio_rd_grant) begin
				rd_save_q <= 1'b0;
			end
			pio_rd_grant_d1 <= pio_rd_grant;
			// set by a write or a served read.
			if (ram_wr | pio_rd_grant_d1) begin
				ack_pend_q <= 1'b1;
			end else if (pio_clk_en) begin
				ack_pend_q <= 1'b0;
			end
			// ack only moves on the slow clock.
			if (pio_clk_en) begin
				ack_q <= ack_pend_q;
			end
			wr_active <= ram_wr;
		end
	end

	assign pio_rsp = '{ack: ack_q, rdata: rdata_q};

	// pio writes go straight in.
	ram_1r1w #(
		.WIDTH      (`TBL_WIDTH),
		.DEPTH_NBITS(`TBL_DEPTH_NBITS)
	) u_ram (
		.clk  (clk),
		.wr   (ram_wr),
		.raddr(ram_raddr),
		.waddr(pio_addr_dw),
		.din  (pio.wdata[`TBL_WIDTH-1:0]),
		.dout (ram_rdata)
	);

endmodule

`default_nettype wire

/* hw/ram_1r1w.sv */
// one-read one-write ram.
// synchronous write, registered read address.
`timescale 1ns/1ps
`default_nettype none

module ram_1r1w #(
	parameter int WIDTH       = 18,
	parameter int DEPTH_NBITS = 6
) (
	input  wire logic                   clk,
	input  wire logic                   wr,
	input  wire logic [DEPTH_NBITS-1:0] raddr,
	input  wire logic [DEPTH_NBITS-1:0] waddr,
	input  wire logic [WIDTH-1:0]       din,
	output logic      [WIDTH-1:0]       dout
);

	// storage, no reset.
	logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

	// read address, one cycle behind raddr.
	logic [DEPTH_NBITS-1:0] raddr_q;

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		raddr_q <= raddr;
	end

	// same-address write gives old data here only if raddr_q moved first.
	assign dout = mem[raddr_q];

endmodule

`default_nettype wire

/* verification/tb_lookup_top.sv */
// testbench for the flow-action lookup engine.
// random table and stream traffic checked against a credit-tracking model.
`timescale 1ns/1ps
`default_nettype none

`include "lookup_defines.svh"

module tb_lookup_top;

	localparam int NUM_ENTRIES = 2**`TBL_DEPTH_NBITS;

	logic                   clk;
	logic                   rst_n      = 1'b0;
	logic                   pio_clk_en = 1'b0;
	pio_pkg::pio_req_t      pio        = '0;
	lookup_pkg::lk_req_t    req        = '0;
	logic                   out_credit = 1'b0;
	pio_pkg::pio_rsp_t      pio_rsp;
	logic                   wr_active;
	lookup_pkg::lk_rsp_t    rsp;
	logic                   in_credit;

	// shadow of the action table.
	lookup_pkg::tbl_entry_t shadow [NUM_ENTRIES];
	// indices whose action is not drop.
	int                     pass_idx [$];
	// results the model expects, in order.
	lookup_pkg::lk_rsp_t    exp_q [$];

	// upstream credits held, downstream credits owed back.
	int          up_credits = `LK_CREDITS;
	int          owed       = 0;
	int          issued     = 0;
	int          bp_seen    = 0;
	logic        stream_on  = 1'b0;
	logic        dense      = 1'b0;
	logic        pass_only  = 1'b0;
	logic        hold_out   = 1'b0;
	logic [1:0]  en_div     = '0;
	logic [31:0] main_rng   = 32'd6;
	logic [31:0] stream_rng = 32'd6 ^ 32'h5bd1e995;

	lookup_top i_lookup_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.pio_clk_en(pio_clk_en),
		.pio       (pio),
		.req       (req),
		.out_credit(out_credit),
		.pio_rsp   (pio_rsp),
		.wr_active (wr_active),
		.rsp       (rsp),
		.in_credit (in_credit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] main_rand();
		main_rng = xorshift32(main_rng);
		return main_rng;
	endfunction

	// reference action with add wrapping at 16 bits.
	function automatic logic [15:0] apply_action(input lookup_pkg::tbl_entry_t e,
			input logic [15:0] p);
		case (e.op)
			lookup_pkg::act_add: return p + e.operand;
			lookup_pkg::act_xor: return p ^ e.operand;
			default:             return p;
		endcase
	endfunction

	task automatic stop_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string why);
		$display("%s at %0t", why, $time);
		stop_run();
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_mismatch(name, 32'(got), 32'(exp));
		end
	endtask

	task automatic check_rsp(input lookup_pkg::lk_rsp_t got, input lookup_pkg::lk_rsp_t exp);
		if (got.index !== exp.index) begin
			report_mismatch("rsp.index", 32'(got.index), 32'(exp.index));
		end
		if (got.payload !== exp.payload) begin
			report_mismatch("rsp.payload", 32'(got.payload), 32'(exp.payload));
		end
	endtask

	task automatic check_pio_rsp(input pio_pkg::pio_rsp_t got, input pio_pkg::pio_rsp_t exp);
		if (got.ack !== exp.ack) begin
			report_mismatch("pio_rsp.ack", 32'(got.ack), 32'(exp.ack));
		end
		if (got.rdata !== exp.rdata) begin
			report_mismatch("pio_rsp.rdata", got.rdata, exp.rdata);
		end
	endtask

	// slow-clock enable on one cycle in four.
	always @(negedge clk) begin
		en_div <= en_div + 2'd1;
		pio_clk_en <= (en_div == 2'd3);
	end

	task automatic wait_ack(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (pio_rsp.ack !== level) begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				report_failure({what, " timed out"});
			end
		end
	endtask

	task automatic pio_write(input logic [`TBL_DEPTH_NBITS-1:0] idx,
			input lookup_pkg::tbl_entry_t e);
		logic [31:0] r;
		r = main_rand();
		@(negedge clk);
		// upper data bits are junk since the table keeps 18.
		pio = '{addr: 32'(idx) << 2, wdata: {r[31:18], e}, rd: 1'b0, wr: 1'b1, sel: 1'b1};
		@(negedge clk);
		pio = '0;
		check_bit("wr_active", wr_active, 1'b1);
		@(negedge clk);
		check_bit("wr_active", wr_active, 1'b0);
		wait_ack(1'b1, 40, "pio write ack rise");
		wait_ack(1'b0, 40, "pio write ack fall");
	endtask

	task automatic pio_read(input logic [`TBL_DEPTH_NBITS-1:0] idx);
		pio_pkg::pio_rsp_t exp;
		exp = '{ack: 1'b1, rdata: 32'(shadow[idx])};
		@(negedge clk);
		pio = '{addr: 32'(idx) << 2, wdata: '0, rd: 1'b1, wr: 1'b0, sel: 1'b1};
		@(negedge clk);
		pio = '0;
		// may wait behind application reads.
		wait_ack(1'b1, 300, "pio read ack rise");
		check_pio_rsp(pio_rsp, exp);
		wait_ack(1'b0, 40, "pio read ack fall");
	endtask

	task automatic wait_issued(input int target, input int limit);
		int n;
		n = 0;
		while (issued < target) begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				report_failure("lookup stream stalled");
			end
		end
	endtask

	// idle means every result seen and every credit back on both sides.
	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 || up_credits != `LK_CREDITS || owed != 0) begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				report_failure("results or credits missing after stream stop");
			end
		end
	endtask

	// upstream, downstream and result monitor.
	// sample first, then drive the next cycle.
	always @(negedge clk) begin
		if (rst_n) begin
			stream_rng = xorshift32(stream_rng);
			if (in_credit) begin
				up_credits++;
				if (up_credits > `LK_CREDITS) begin
					report_failure("in_credit returned more credits than spent");
				end
			end
			if (rsp.valid) begin
				if (owed >= `LK_CREDITS) begin
					report_failure("result sent without an output credit");
				end
				if (exp_q.size() == 0) begin
					report_failure("result with no request to match");
				end
				owed++;
				bp_seen++;
				check_rsp(rsp, exp_q.pop_front());
			end
			// downstream hands back one credit per result taken.
			if (!hold_out && owed > 0 && stream_rng[0]) begin
				out_credit = 1'b1;
				owed--;
			end else begin
				out_credit = 1'b0;
			end
			req = '0;
			if (stream_on && up_credits > 0 && (dense || stream_rng[1])) begin
				req.valid = 1'b1;
				req.payload = stream_rng[31:16];
				if (pass_only) begin
					req.index = `TBL_DEPTH_NBITS'(pass_idx[stream_rng[15:8] % pass_idx.size()]);
				end else begin
					req.index = stream_rng[7:2];
				end
				up_credits--;
				issued++;
				if (shadow[req.index].op != lookup_pkg::act_drop) begin
					exp_q.push_back('{valid: 1'b1, index: req.index,
						payload: apply_action(shadow[req.index], req.payload)});
				end
			end
		end
	end

	initial begin
		logic [31:0] r;
		int target;
		// outputs quiet through reset and just after.
		repeat (8) begin
			@(negedge clk);
			check_bit("rsp.valid", rsp.valid, 1'b0);
			check_bit("in_credit", in_credit, 1'b0);
			check_bit("pio_rsp.ack", pio_rsp.ack, 1'b0);
		end
		rst_n <= 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_bit("rsp.valid", rsp.valid, 1'b0);
			check_bit("in_credit", in_credit, 1'b0);
			check_bit("pio_rsp.ack", pio_rsp.ack, 1'b0);
		end

		// fill the whole table, then read it back.
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			r = main_rand();
			shadow[i] = '{op: lookup_pkg::action_e'(r[1:0]), operand: r[31:16]};
			if (shadow[i].op != lookup_pkg::act_drop) begin
				pass_idx.push_back(i);
			end
			pio_write(`TBL_DEPTH_NBITS'(i), shadow[i]);
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			pio_read(`TBL_DEPTH_NBITS'(i));
		end
		if (pass_idx.size() == 0) begin
			report_failure("table holds no entry that is not drop");
		end

		// mixed actions with drops, random downstream credits.
		target = issued + 200;
		@(posedge clk);
		stream_on = 1'b1;
		wait_issued(target, 4000);
		@(posedge clk);
		stream_on = 1'b0;
		wait_idle(400);

		// downstream holds its credits back.
		@(posedge clk);
		hold_out = 1'b1;
		pass_only = 1'b1;
		bp_seen = 0;
		stream_on = 1'b1;
		repeat (60) @(negedge clk);
		if (bp_seen != `LK_CREDITS) begin
			report_failure("results under withheld output credits did not stop at the credit count");
		end
		if (up_credits != 0 || exp_q.size() != `LK_CREDITS) begin
			report_failure("upstream did not stall with the output buffer full");
		end
		@(posedge clk);
		stream_on = 1'b0;
		hold_out = 1'b0;
		pass_only = 1'b0;
		wait_idle(400);

		// pio reads against a dense lookup stream.
		@(posedge clk);
		dense = 1'b1;
		stream_on = 1'b1;
		for (int i = 0; i < 16; i++) begin
			r = main_rand();
			pio_read(r[7:2]);
		end
		@(posedge clk);
		stream_on = 1'b0;
		dense = 1'b0;
		wait_idle(400);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
